// File: rtl/fpc_pkg.sv
// Read request path definitions
`default_nettype none

package fpc_pkg;

   // DMA channel count
   localparam int unsigned n_channels = 4;

   // Command fields, all in 8-byte units
   localparam int unsigned addr_width  = 61;   // Start address
   localparam int unsigned count_width = 19;   // Transfer length

   // 64 units of 8 bytes make one 512-byte block
   localparam int unsigned block_shift       = 6;
   localparam int unsigned block_addr_width  = addr_width - block_shift;   // 55
   localparam int unsigned block_count_width = count_width - block_shift;  // 13

   // Request tag
   localparam int unsigned tag_width     = 8;
   localparam int unsigned channel_width = 2;

   // tag_layout
   //   bit  7..6   zero
   //   bit  5..4   channel number
   //   bit  3      zero
   //   bit  2..0   tag low part, upper bits zero when fewer tags per channel
   // Built by fpc_rr_mux, decoded by each fpc_tag_pool
   localparam int unsigned tag_channel_lsb     = 4;
   localparam int unsigned tag_low_field_width = 3;

   // Scanner phase, one pass per granted channel
   typedef enum logic [1:0]
   {
      check,   // Test pending and tag free for current channel
      load,    // Capture block address and tag low
      step,    // Advance the splitter
      issue    // Hold request until accepted
   } scan_phase_t;

endpackage

`default_nettype wire

// File: rtl/fpc_block_splitter.sv
// Per-channel block splitter
`timescale 1ns/100ps
`default_nettype none

module fpc_block_splitter
(
   input  wire logic                                  clock,
   input  wire logic                                  reset,
   // Command, sampled on strobe
   input  wire logic                                  cmd_valid,
   input  wire logic [fpc_pkg::addr_width-1:0]        cmd_addr,    // 8-byte units
   input  wire logic [fpc_pkg::count_width-1:0]       cmd_count,   // 8-byte units
   output logic                                       cmd_ready,
   // Block stream towards the scanner
   input  wire logic                                  block_step,
   output logic                                       block_pending,
   output logic [fpc_pkg::block_addr_width-1:0]       block_addr
);

   // Blocks still to request
   logic [fpc_pkg::block_count_width-1:0] block_count;

   // Remaining count is control state
   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         block_count <= '0;
      end
      else if (cmd_valid)
      begin
         // Partial block in low bits is dropped
         block_count <= cmd_count[fpc_pkg::count_width-1:fpc_pkg::block_shift];
      end
      else if (block_step)
      begin
         block_count <= block_count - 1'b1;   // One block issued
      end
   end

   // Address register, only meaningful while pending
   always_ff @(posedge clock)
   begin
      if (cmd_valid)
      begin
         block_addr <= cmd_addr[fpc_pkg::addr_width-1:fpc_pkg::block_shift];
      end
      else if (block_step)
      begin
         block_addr <= block_addr + 1'b1;   // Next 512-byte block
      end
   end

   // Pending from the count register, one cycle after the command
   assign block_pending = (block_count != '0);
   assign cmd_ready     = ~block_pending;   // Idle channel takes a new command

   // Command source must wait for the previous transfer to drain
   cmd_while_busy: assert property
   (
      @(posedge clock) disable iff (reset)
      cmd_valid |-> cmd_ready
   );

   // Scanner only steps a channel it found pending
   step_while_idle: assert property
   (
      @(posedge clock) disable iff (reset)
      block_step |-> block_pending
   );

endmodule

`default_nettype wire

// File: rtl/fpc_tag_pool.sv
// Per-channel read tag pool
`timescale 1ns/100ps
`default_nettype none

module fpc_tag_pool
#(
   parameter int tag_low_width = 3,   // 1 to 3, sets tags per channel
   parameter int channel_id    = 0    // Channel field this pool answers to
)
(
   input  wire logic                              clock,
   input  wire logic                              reset,
   // Offer towards the scanner
   input  wire logic                              tag_take,
   output logic                                   tag_free,
   output logic [tag_low_width-1:0]               tag_low,
   // Completion return
   input  wire logic                              cpl_valid,
   input  wire logic [fpc_pkg::tag_width-1:0]     cpl_tag
);

   localparam int n_tags = 2 ** tag_low_width;

   logic [n_tags-1:0]                  busy;          // One bit per outstanding tag
   logic [fpc_pkg::channel_width-1:0]  cpl_channel;   // Channel field of completion
   logic [tag_low_width-1:0]           release_idx;   // Tag low of completion
   logic                               release_hit;   // Completion belongs here

   // Decode the completion tag
   assign cpl_channel = cpl_tag[fpc_pkg::tag_channel_lsb +: fpc_pkg::channel_width];
   assign release_idx = cpl_tag[tag_low_width-1:0];
   assign release_hit = cpl_valid && (cpl_channel == fpc_pkg::channel_width'(channel_id));

   // Lowest free tag wins
   always_comb
   begin
      tag_low = '0;
      for (int t = n_tags - 1; t >= 0; t--)
      begin
         if (!busy[t])
         begin
            tag_low = tag_low_width'(t);
         end
      end
   end

   assign tag_free = ~&busy;   // Any zero bit

   // Take sets, completion clears
   // A taken tag is always free and a released one busy, so no overlap
   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         busy <= '0;   // All tags free
      end
      else
      begin
         if (tag_take)
         begin
            busy[tag_low] <= 1'b1;
         end
         if (release_hit)
         begin
            busy[release_idx] <= 1'b0;
         end
      end
   end

   // Scanner only grants when a tag was offered
   take_while_empty: assert property
   (
      @(posedge clock) disable iff (reset)
      tag_take |-> tag_free
   );

   // Completer must not return a tag that was never issued
   release_of_idle: assert property
   (
      @(posedge clock) disable iff (reset)
      release_hit |-> busy[release_idx]
   );

endmodule

`default_nettype wire

// File: rtl/fpc_rr_mux.sv
// Round-robin read request scanner
`timescale 1ns/100ps
`default_nettype none

module fpc_rr_mux
#(
   parameter logic [fpc_pkg::n_channels-1:0] channel_enable = 4'b1111,
   parameter int                             tag_low_width  = 3
)
(
   input  wire logic                                                    clock,
   input  wire logic                                                    reset,
   // From splitters
   input  wire logic [fpc_pkg::n_channels-1:0]                          block_pending,
   input  wire logic [fpc_pkg::n_channels*fpc_pkg::block_addr_width-1:0] block_addr,
   output logic [fpc_pkg::n_channels-1:0]                               block_step,
   // From tag pools
   input  wire logic [fpc_pkg::n_channels-1:0]                          tag_free,
   input  wire logic [fpc_pkg::n_channels*tag_low_width-1:0]            tag_low,
   output logic [fpc_pkg::n_channels-1:0]                               tag_take,
   // Merged request port
   output logic                                                         req_valid,
   output logic [fpc_pkg::block_addr_width-1:0]                         req_addr,
   output logic [fpc_pkg::tag_width-1:0]                                req_tag,
   input  wire logic                                                    req_ready
);

   fpc_pkg::scan_phase_t                      phase;      // Scanner phase
   logic [fpc_pkg::channel_width-1:0]         chan;       // Channel under scan
   logic [fpc_pkg::n_channels-1:0]            chan_sel;   // One-hot of chan
   logic                                      chan_go;    // Current channel can issue
   logic [tag_low_width-1:0]                  tag_low_q;  // Captured tag low
   logic [fpc_pkg::tag_low_field_width-1:0]   tag_field;  // Zero-extended to layout

   // Enabled, has a block and holds a tag
   assign chan_go = channel_enable[chan] && block_pending[chan] && tag_free[chan];

   assign chan_sel  = fpc_pkg::n_channels'(1) << chan;
   assign req_valid = (phase == fpc_pkg::issue);

   // Strobes back to the chosen channel only
   assign block_step = (phase == fpc_pkg::step) ? chan_sel : '0;
   assign tag_take   = (phase == fpc_pkg::load) ? chan_sel : '0;   // Same tag as captured

   // Tag per layout: 00, channel, 0, tag low
   assign tag_field = fpc_pkg::tag_low_field_width'(tag_low_q);
   assign req_tag   = {2'b00, chan, 1'b0, tag_field};

   // Phase and channel counter
   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         phase <= fpc_pkg::check;
         chan  <= '0;   // Start at channel 0
      end
      else
      begin
         case (phase)
            fpc_pkg::check:
            begin
               if (chan_go)
               begin
                  phase <= fpc_pkg::load;
               end
               else
               begin
                  chan <= chan + 1'b1;   // Skip to next channel
               end
            end
            fpc_pkg::load:
            begin
               phase <= fpc_pkg::step;
            end
            fpc_pkg::step:
            begin
               phase <= fpc_pkg::issue;
            end
            fpc_pkg::issue:
            begin
               // Hold everything under back-pressure
               if (req_ready)
               begin
                  phase <= fpc_pkg::check;
                  chan  <= chan + 1'b1;   // Wraps 3 to 0
               end
            end
            default:
            begin
               phase <= fpc_pkg::check;
            end
         endcase
      end
   end

   // Request payload, captured before the splitter steps
   always_ff @(posedge clock)
   begin
      if (phase == fpc_pkg::load)
      begin
         req_addr  <= block_addr[chan*fpc_pkg::block_addr_width +: fpc_pkg::block_addr_width];
         tag_low_q <= tag_low[chan*tag_low_width +: tag_low_width];
      end
   end

   // Stalled request keeps phase, address and tag
   req_stable: assert property
   (
      @(posedge clock) disable iff (reset)
      (phase == fpc_pkg::issue && !req_ready) |=>
         (phase == fpc_pkg::issue && $stable(req_addr) && $stable(req_tag))
   );

   // Each step follows the take of the same channel one cycle before
   step_after_take: assert property
   (
      @(posedge clock) disable iff (reset)
      |block_step |-> (block_step == $past(tag_take))
   );

endmodule

`default_nettype wire

// File: rtl/fpc_read_request.sv
// Read request path top level
`timescale 1ns/100ps
`default_nettype none

module fpc_read_request
#(
   parameter logic [fpc_pkg::n_channels-1:0] channel_enable = 4'b1111,
   parameter int                             tag_low_width  = 3
)
(
   input  wire logic                                clock,
   input  wire logic                                reset,
   // DMA commands, address and count shared
   input  wire logic [fpc_pkg::n_channels-1:0]      cmd_valid,
   input  wire logic [fpc_pkg::addr_width-1:0]      cmd_addr,
   input  wire logic [fpc_pkg::count_width-1:0]     cmd_count,
   output logic [fpc_pkg::n_channels-1:0]           cmd_ready,
   // Completion tag return
   input  wire logic                                cpl_valid,
   input  wire logic [fpc_pkg::tag_width-1:0]       cpl_tag,
   // Block read requests
   output logic                                     req_valid,
   output logic [fpc_pkg::block_addr_width-1:0]     req_addr,
   output logic [fpc_pkg::tag_width-1:0]            req_tag,
   input  wire logic                                req_ready
);

   localparam int baw = fpc_pkg::block_addr_width;

   // Per-channel buses towards the scanner
   logic [fpc_pkg::n_channels-1:0]               block_pending;
   logic [fpc_pkg::n_channels*baw-1:0]           block_addr;
   logic [fpc_pkg::n_channels-1:0]               block_step;
   logic [fpc_pkg::n_channels-1:0]               tag_free;
   logic [fpc_pkg::n_channels*tag_low_width-1:0] tag_low;
   logic [fpc_pkg::n_channels-1:0]               tag_take;

   for (genvar i = 0; i < fpc_pkg::n_channels; i++)
   begin : g_channel
      if (channel_enable[i])
      begin : g_on
         fpc_block_splitter i_fpc_block_splitter
         (
            .clock         (clock),
            .reset         (reset),
            .cmd_valid     (cmd_valid[i]),
            .cmd_addr      (cmd_addr),
            .cmd_count     (cmd_count),
            .cmd_ready     (cmd_ready[i]),
            .block_step    (block_step[i]),
            .block_pending (block_pending[i]),
            .block_addr    (block_addr[i*baw +: baw])
         );

         fpc_tag_pool #(
            .tag_low_width (tag_low_width),
            .channel_id    (i)
         ) i_fpc_tag_pool (
            .clock     (clock),
            .reset     (reset),
            .tag_take  (tag_take[i]),
            .tag_free  (tag_free[i]),
            .tag_low   (tag_low[i*tag_low_width +: tag_low_width]),
            .cpl_valid (cpl_valid),
            .cpl_tag   (cpl_tag)
         );
      end
      else
      begin : g_off
         // Absent channel, never pending, never free, never ready
         assign cmd_ready[i]                             = 1'b0;
         assign block_pending[i]                         = 1'b0;
         assign block_addr[i*baw +: baw]                 = '0;
         assign tag_free[i]                              = 1'b0;
         assign tag_low[i*tag_low_width +: tag_low_width] = '0;
      end
   end

   fpc_rr_mux #(
      .channel_enable (channel_enable),
      .tag_low_width  (tag_low_width)
   ) i_fpc_rr_mux (
      .clock         (clock),
      .reset         (reset),
      .block_pending (block_pending),
      .block_addr    (block_addr),
      .block_step    (block_step),
      .tag_free      (tag_free),
      .tag_low       (tag_low),
      .tag_take      (tag_take),
      .req_valid     (req_valid),
      .req_addr      (req_addr),
      .req_tag       (req_tag),
      .req_ready     (req_ready)
   );

endmodule

`default_nettype wire

// File: dv/fpc_read_request_tb.sv
// Read request path testbench
`timescale 1ns/100ps
`default_nettype none

module fpc_read_request_tb;

   localparam int clock_period  = 20;
   localparam int drive_delay   = 2;       // Input skew after rising edge
   localparam int tlw           = 3;       // Tag low width under test
   localparam int n_tags        = 1 << tlw;
   localparam int exp_depth     = 512;     // Expected blocks per channel
   localparam int ready_timeout = 5000;    // Cycles to wait for cmd_ready
   localparam int drain_timeout = 20000;   // Cycles to wait for idle

   logic                                   clock;
   logic                                   reset;
   logic [fpc_pkg::n_channels-1:0]         cmd_valid;
   logic [fpc_pkg::addr_width-1:0]         cmd_addr;
   logic [fpc_pkg::count_width-1:0]        cmd_count;
   logic [fpc_pkg::n_channels-1:0]         cmd_ready;
   logic                                   cpl_valid;
   logic [fpc_pkg::tag_width-1:0]          cpl_tag;
   logic                                   req_valid;
   logic [fpc_pkg::block_addr_width-1:0]   req_addr;
   logic [fpc_pkg::tag_width-1:0]          req_tag;
   logic                                   req_ready;

   // Reference model state
   logic [fpc_pkg::block_addr_width-1:0] exp_mem [0:3][0:exp_depth-1];   // Expected addresses
   int       head [0:3];
   int       tail [0:3];
   bit       busy_model [0:3][0:n_tags-1];   // Tags out on the bus
   int       outstanding [0:3];
   int       cur_delay [0:3];                // Completion delay per channel
   logic [7:0] cpl_tags [$];                 // Completions waiting to go out
   int       cpl_dues [$];
   int       cur_mask;                       // Ready-stall mask
   int       ready_mask;                     // Mask latched at the edge
   logic [7:0] lfsr;
   int       cycle;
   int       errors;
   // Fairness and stall tracking
   bit       have_prev;
   bit       next_ok;
   int       prev_chan;
   int       prev_cycle;
   int       stalls;
   bit       stalled;
   logic [fpc_pkg::block_addr_width-1:0] held_addr;
   logic [fpc_pkg::tag_width-1:0]        held_tag;

   fpc_read_request #(
      .channel_enable (4'b1111),
      .tag_low_width  (tlw)
   ) i_fpc_read_request (
      .clock     (clock),
      .reset     (reset),
      .cmd_valid (cmd_valid),
      .cmd_addr  (cmd_addr),
      .cmd_count (cmd_count),
      .cmd_ready (cmd_ready),
      .cpl_valid (cpl_valid),
      .cpl_tag   (cpl_tag),
      .req_valid (req_valid),
      .req_addr  (req_addr),
      .req_tag   (req_tag),
      .req_ready (req_ready)
   );

   always #(clock_period / 2) clock = ~clock;

   // Fibonacci LFSR, x^8 + x^6 + x^5 + x^4 + 1
   function automatic logic [7:0] lfsr_step(input logic [7:0] s);
      return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
   endfunction

   task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                              input string what);
      if (actual !== expected)
      begin
         errors++;
         $display("** Error at %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
      end
   endtask

   // Channel has a block left and a free tag
   function automatic bit eligible(input int ch);
      bit any_free;
      any_free = 0;
      for (int t = 0; t < n_tags; t++)
      begin
         if (!busy_model[ch][t])
         begin
            any_free = 1;
         end
      end
      return (head[ch] != tail[ch]) && any_free;
   endfunction

   function automatic bit drained();
      bit idle;
      idle = !req_valid && (cpl_tags.size() == 0);
      for (int ch = 0; ch < fpc_pkg::n_channels; ch++)
      begin
         if (head[ch] != tail[ch] || outstanding[ch] != 0)
         begin
            idle = 0;
         end
      end
      return idle;
   endfunction

   // One accepted request against the model
   task automatic check_request();
      int c;
      int low;
      c   = req_tag[5:4];   // Channel field
      low = req_tag[2:0];
      check_value(req_tag[7:6], 0, "reserved tag bits 7..6");
      check_value(req_tag[3], 0, "reserved tag bit 3");
      check_value(head[c] != tail[c], 1, "request from channel with no block expected");
      if (head[c] != tail[c])
      begin
         check_value(req_addr, exp_mem[c][head[c] % exp_depth], "block address");
         head[c]++;
      end
      check_value(busy_model[c][low], 0, "tag reused before its completion");
      if (have_prev && next_ok)
      begin
         check_value(c, (prev_chan + 1) % fpc_pkg::n_channels, "round-robin channel order");
         check_value(cycle - prev_cycle, 4 + stalls, "cycles between transfers");
      end
      busy_model[c][low] = 1;
      outstanding[c]++;
      cpl_tags.push_back(req_tag);
      cpl_dues.push_back(cycle + cur_delay[c]);
      prev_chan  = c;
      prev_cycle = cycle;
      stalls     = 0;
      have_prev  = 1;
      next_ok    = eligible((c + 1) % fpc_pkg::n_channels);   // Next in line ready now
   endtask

   // Sample at the rising edge, before the DUT registers update
   task automatic sample_edge();
      logic [fpc_pkg::block_addr_width-1:0] base;
      int n;
      for (int ch = 0; ch < fpc_pkg::n_channels; ch++)
      begin
         if (cmd_valid[ch])
         begin
            base = cmd_addr >> fpc_pkg::block_shift;   // Start block
            n    = cmd_count >> fpc_pkg::block_shift;  // Whole blocks only
            for (int k = 0; k < n; k++)
            begin
               exp_mem[ch][tail[ch] % exp_depth] = base + k;
               tail[ch]++;
            end
         end
      end
      if (cpl_valid)
      begin
         busy_model[cpl_tag[5:4]][cpl_tag[2:0]] = 0;   // Tag back in pool
         outstanding[cpl_tag[5:4]]--;
      end
      if (stalled)
      begin
         check_value(req_valid, 1, "req_valid dropped under back-pressure");
         check_value(req_addr, held_addr, "req_addr changed under back-pressure");
         check_value(req_tag, held_tag, "req_tag changed under back-pressure");
      end
      if (req_valid && req_ready)
      begin
         check_request();
      end
      else if (req_valid)
      begin
         stalls++;
      end
      stalled   = req_valid && !req_ready;
      held_addr = req_addr;
      held_tag  = req_tag;
   endtask

   // Ready pattern and completion return
   task automatic drive_inputs();
      logic [1:0] r;
      bit sent;
      r[0] = lfsr[0];
      lfsr = lfsr_step(lfsr);
      r[1] = lfsr[0];
      lfsr = lfsr_step(lfsr);
      req_ready = ((r & ready_mask[1:0]) == 2'b00);
      sent      = 0;
      cpl_valid = 0;
      for (int i = 0; i < cpl_tags.size(); i++)
      begin
         if (!sent && cpl_dues[i] <= cycle)   // Oldest due completion first
         begin
            cpl_valid = 1;
            cpl_tag   = cpl_tags[i];
            cpl_tags.delete(i);
            cpl_dues.delete(i);
            sent = 1;
         end
      end
   endtask

   always @(posedge clock)
   begin
      cycle++;
      ready_mask = cur_mask;   // Mask for the coming cycle
      if (!reset)
      begin
         sample_edge();
      end
      #drive_delay;
      drive_inputs();
   end

   task automatic issue_command(input int ch, input logic [63:0] addr, input logic [63:0] count,
                                input int mask, input int delay, output bit ok);
      int waited;
      waited = 0;
      ok     = 1;
      while (!cmd_ready[ch] && waited < ready_timeout)
      begin
         @(posedge clock);
         #drive_delay;
         waited++;
      end
      if (!cmd_ready[ch])
      begin
         $display("Timeout: channel %0d never became ready for a new command", ch);
         errors++;
         ok = 0;
      end
      else
      begin
         cur_mask      = mask;
         cur_delay[ch] = delay;
         cmd_addr      = addr[fpc_pkg::addr_width-1:0];
         cmd_count     = count[fpc_pkg::count_width-1:0];
         cmd_valid[ch] = 1;
         @(posedge clock);
         #drive_delay;
         cmd_valid = '0;
         // Short command leaves the channel idle
         check_value(cmd_ready[ch], (count[fpc_pkg::count_width-1:0] < 64),
                     "cmd_ready after command");
      end
   endtask

   task automatic wait_drain(output bit ok);
      int waited;
      waited = 0;
      while (!drained() && waited < drain_timeout)
      begin
         @(posedge clock);
         #drive_delay;
         waited++;
      end
      ok = drained();
      if (!ok)
      begin
         $display("Timeout: requests or completions still outstanding after %0d cycles",
                  drain_timeout);
         errors++;
      end
   endtask

   initial
   begin
      int fd;
      int n;
      int f_ch;
      int f_mask;
      int f_delay;
      logic [63:0] f_addr;
      logic [63:0] f_count;
      string line;
      bit ok;
      clock      = 0;
      reset      = 1;
      cmd_valid  = '0;
      cmd_addr   = '0;
      cmd_count  = '0;
      cpl_valid  = 0;
      cpl_tag    = '0;
      req_ready  = 1;
      lfsr       = 8'd62;   // Seed
      cur_mask   = 0;
      ready_mask = 0;
      cycle      = 0;
      errors     = 0;
      have_prev  = 0;
      next_ok    = 0;
      stalls     = 0;
      stalled    = 0;
      for (int ch = 0; ch < fpc_pkg::n_channels; ch++)
      begin
         head[ch]        = 0;
         tail[ch]        = 0;
         outstanding[ch] = 0;
         cur_delay[ch]   = 1;
         for (int t = 0; t < n_tags; t++)
         begin
            busy_model[ch][t] = 0;
         end
      end
      repeat (10) @(posedge clock);
      #drive_delay;
      check_value(req_valid, 0, "req_valid after reset");
      check_value(cmd_ready, 4'hf, "cmd_ready after reset");
      reset = 0;
      ok = 1;
      fd = $fopen("dv/fpc_read_request_cases.txt", "r");
      if (fd == 0)
      begin
         $display("Could not open the case file dv/fpc_read_request_cases.txt");
         errors++;
         ok = 0;
      end
      while (ok && !$feof(fd))
      begin
         n = $fgets(line, fd);
         if (n > 0 && line.len() > 1 && line[0] != "#")   // Skip comments and blanks
         begin
            n = $sscanf(line, "%d %h %h %d %d", f_ch, f_addr, f_count, f_mask, f_delay);
            if (n == 5 && f_ch == 4)
            begin
               wait_drain(ok);   // Barrier between groups
            end
            else if (n == 5)
            begin
               issue_command(f_ch, f_addr, f_count, f_mask, f_delay, ok);
            end
         end
      end
      if (fd != 0)
      begin
         $fclose(fd);
      end
      if (ok)
      begin
         wait_drain(ok);
      end
      $display("Run finished with %0d errors", errors);
      if (errors == 0)
      begin
         $display("Simulation passed");
      end
      else
      begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: dv/fpc_read_request_cases.txt
# channel start_addr(hex) count(hex) stall_mask cpl_delay, address and count in 8-byte units
# channel 4 is a barrier that waits until every request and completion has drained
0 0000000000001000 00100 0 6
4 0 0 0 0
1 0000000000002000 0003f 0 6
2 0000000000002400 00000 0 6
3 0000000000003025 001c7 0 6
4 0 0 0 0
0 0000000000010000 00400 0 4
1 0000000000020000 00400 0 4
2 0000000000030000 00400 0 4
3 0000000000040000 00400 0 4
4 0 0 0 0
2 0000000000050000 00300 0 150
0 0000000000060000 00200 0 3
1 0000000000070000 00200 0 3
3 0000000000080000 00200 0 3
4 0 0 0 0
0 0000000000090000 00280 1 8
1 00000000000a0040 00280 1 8
2 00000000000b0080 00280 1 8
3 00000000000c00c0 00280 1 8
4 0 0 0 0
1 1ffffffffffff000 00080 3 10
3 0000000000100000 00140 3 2
0 0000000000000000 00300 3 40

// File: fpc_read_request.f
rtl/fpc_pkg.sv
rtl/fpc_block_splitter.sv
rtl/fpc_tag_pool.sv
rtl/fpc_rr_mux.sv
rtl/fpc_read_request.sv
dv/fpc_read_request_tb.sv
